// File: alu.sv
`default_nettype none

`include "exec_defs.svh"

module alu
    import exec_pkg::*;
(
    input  logic [`EXEC_XLEN-1:0] opnd1,
    input  logic [`EXEC_XLEN-1:0] opnd2,
    input  alu_op_e               op,
    output logic [`EXEC_XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = opnd2[4:0]; // RV32I uses the low five bits.

    always_comb begin
        case (op)
            ALU_ADD:  result = opnd1 + opnd2;
            ALU_SUB:  result = opnd1 - opnd2;
            ALU_SLL:  result = opnd1 << shamt;
            ALU_SLT:  result = {{(`EXEC_XLEN-1){1'b0}}, $signed(opnd1) < $signed(opnd2)};
            ALU_SLTU: result = {{(`EXEC_XLEN-1){1'b0}}, opnd1 < opnd2};
            ALU_XOR:  result = opnd1 ^ opnd2;
            ALU_SRL:  result = opnd1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(opnd1) >>> shamt);
            ALU_OR:   result = opnd1 | opnd2;
            ALU_AND:  result = opnd1 & opnd2;
            default:  result = '0; // Unused encodings.
        endcase
    end

endmodule

`default_nettype wire

// File: exec_core_top.sv
`default_nettype none

`include "exec_defs.svh"

module exec_core_top
    import exec_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  uop_t    uop,
    input  logic    uop_valid,
    output logic    uop_ready,
    input  logic    flush,
    output commit_t commit,
    output logic    commit_valid,
    input  logic    commit_ready
);

    logic [`EXEC_RIDX_W-1:0] rs1_addr;
    logic [`EXEC_RIDX_W-1:0] rs2_addr;
    logic [`EXEC_XLEN-1:0]   rs1_data;
    logic [`EXEC_XLEN-1:0]   rs2_data;
    logic                    wen;
    logic [`EXEC_RIDX_W-1:0] waddr;
    logic [`EXEC_XLEN-1:0]   wdata;
    logic                    release_en;
    logic [`EXEC_RIDX_W-1:0] release_rd;
    logic                    kill_en;
    logic [`EXEC_RIDX_W-1:0] kill_rd;
    ex_req_t                 req;
    logic                    req_valid;
    logic                    req_ready;
    commit_t                 ex_out;
    logic                    ex_valid;
    logic                    ex_ready;

    issue_stage u_issue (
        .clock, .reset, .uop, .uop_valid, .uop_ready, .rs1_addr, .rs2_addr,
        .rs1_data, .rs2_data, .release_en, .release_rd, .kill_en, .kill_rd,
        .req, .req_valid, .req_ready
    );

    exu_stage u_exu (
        .clock, .reset, .flush, .req, .req_valid, .req_ready,
        .ex_out, .ex_valid, .ex_ready, .kill_en, .kill_rd
    );

    writeback_stage u_wb (
        .clock, .reset, .ex_out, .ex_valid, .ex_ready, .commit, .commit_valid,
        .commit_ready, .wen, .waddr, .wdata, .release_en, .release_rd
    );

    reg_file u_rf (
        .clock, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wen, .waddr, .wdata
    );

endmodule

`default_nettype wire

// File: exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Data path width of the core.
`define EXEC_XLEN 32

// Number of architectural integer registers.
`define EXEC_NREGS 32

// Width of a register index.
`define EXEC_RIDX_W 5

// ALU opcode width, wide enough for the ten RV32I operations.
`define EXEC_ALU_OP_W 4

// Width of the funct3 field carried with each op.
`define EXEC_FUNCT3_W 3

`endif

// File: exec_pkg.sv
`default_nettype none

`include "exec_defs.svh"

package exec_pkg;

    typedef enum logic [`EXEC_ALU_OP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic {
        SRC1_RS1 = 1'b0,
        SRC1_PC  = 1'b1
    } src1_sel_e;

    typedef enum logic {
        SRC2_IMM = 1'b0,
        SRC2_RS2 = 1'b1
    } src2_sel_e;

    // Decoded micro-op as delivered by the decoder.
    typedef struct packed {
        logic [`EXEC_XLEN-1:0]     pc;
        logic [`EXEC_RIDX_W-1:0]   rs1;
        logic [`EXEC_RIDX_W-1:0]   rs2;
        logic [`EXEC_RIDX_W-1:0]   rd;
        logic [`EXEC_XLEN-1:0]     imm;
        alu_op_e                   alu_op;
        src1_sel_e                 src1_sel;
        src2_sel_e                 src2_sel;
        logic                      inv_flag;
        logic                      branch_flag;
        logic                      jump_flag;
        logic                      reg_wen;
        logic                      mem_wen;
        logic                      mem_ren;
        logic [`EXEC_FUNCT3_W-1:0] funct3;
    } uop_t;

    // Operands resolved, ready for the ALU.
    typedef struct packed {
        logic [`EXEC_XLEN-1:0]     pc;
        logic [`EXEC_XLEN-1:0]     opnd1;
        logic [`EXEC_XLEN-1:0]     opnd2;
        logic [`EXEC_XLEN-1:0]     rs2_value;
        logic [`EXEC_XLEN-1:0]     imm;
        logic [`EXEC_RIDX_W-1:0]   rd;
        alu_op_e                   alu_op;
        logic                      inv_flag;
        logic                      branch_flag;
        logic                      jump_flag;
        logic                      reg_wen;
        logic                      mem_wen;
        logic                      mem_ren;
        logic [`EXEC_FUNCT3_W-1:0] funct3;
    } ex_req_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]   pc;
        logic [`EXEC_XLEN-1:0]   result;
        logic [`EXEC_RIDX_W-1:0] rd;
        logic                    reg_wen;
        logic                    mem_wen;
        logic                    mem_ren;
        logic                    taken;
        logic [`EXEC_XLEN-1:0]   rs2_value; // Store data for a later memory stage.
    } commit_t;

endpackage

`default_nettype wire

// File: exu_stage.sv
`default_nettype none

`include "exec_defs.svh"

module exu_stage
    import exec_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    flush,
    input  ex_req_t                 req,
    input  logic                    req_valid,
    output logic                    req_ready,
    output commit_t                 ex_out,
    output logic                    ex_valid,
    input  logic                    ex_ready,
    output logic                    kill_en,
    output logic [`EXEC_RIDX_W-1:0] kill_rd
);

    ex_req_t               pay_q;
    logic                  reg_wen_q;
    logic                  mem_wen_q;
    logic                  mem_ren_q;
    logic                  jump_q;
    logic                  branch_q;
    logic                  xfer;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic [`EXEC_XLEN-1:0] result;

    assign req_ready = ex_ready; // Ready passes straight through.
    assign xfer      = req_valid & req_ready;

    // A flushed op frees its scoreboard entry right away.
    assign kill_en = xfer & flush & req.reg_wen & (req.rd != '0);
    assign kill_rd = req.rd;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (xfer) begin
            ex_valid <= ~flush;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            reg_wen_q <= 1'b0;
            mem_wen_q <= 1'b0;
            mem_ren_q <= 1'b0;
            jump_q    <= 1'b0;
            branch_q  <= 1'b0;
        end else if (xfer) begin
            reg_wen_q <= req.reg_wen & ~flush;
            mem_wen_q <= req.mem_wen & ~flush;
            mem_ren_q <= req.mem_ren & ~flush;
            jump_q    <= req.jump_flag & ~flush;
            branch_q  <= req.branch_flag & ~flush;
        end
    end

    always_ff @(posedge clock) begin
        if (xfer) begin
            pay_q <= req;
        end
    end

    alu u_alu (
        .opnd1  (pay_q.opnd1),
        .opnd2  (pay_q.opnd2),
        .op     (pay_q.alu_op),
        .result (alu_result)
    );

    // Invert flag turns eq into ne, lt into ge.
    assign result = alu_result ^ {{(`EXEC_XLEN-1){1'b0}}, pay_q.inv_flag};

    always_comb begin
        ex_out           = '0;
        ex_out.pc        = pay_q.pc;
        ex_out.result    = result;
        ex_out.rd        = pay_q.rd;
        ex_out.reg_wen   = reg_wen_q;
        ex_out.mem_wen   = mem_wen_q;
        ex_out.mem_ren   = mem_ren_q;
        ex_out.taken     = jump_q | (branch_q & result[0]);
        ex_out.rs2_value = pay_q.rs2_value;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
exec_pkg.sv
reg_file.sv
alu.sv
issue_stage.sv
exu_stage.sv
writeback_stage.sv
exec_core_top.sv
tb_exec_core.sv

// File: issue_stage.sv
`default_nettype none

`include "exec_defs.svh"

module issue_stage
    import exec_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  uop_t                    uop,
    input  logic                    uop_valid,
    output logic                    uop_ready,
    output logic [`EXEC_RIDX_W-1:0] rs1_addr,
    output logic [`EXEC_RIDX_W-1:0] rs2_addr,
    input  logic [`EXEC_XLEN-1:0]   rs1_data,
    input  logic [`EXEC_XLEN-1:0]   rs2_data,
    input  logic                    release_en,
    input  logic [`EXEC_RIDX_W-1:0] release_rd,
    input  logic                    kill_en,
    input  logic [`EXEC_RIDX_W-1:0] kill_rd,
    output ex_req_t                 req,
    output logic                    req_valid,
    input  logic                    req_ready
);

    logic [`EXEC_NREGS-1:0] busy;
    logic                   started;
    logic                   hazard;
    logic                   accept;
    logic                   sb_set;

    assign rs1_addr = uop.rs1;
    assign rs2_addr = uop.rs2;

    // A busy rd is a hazard as well, so each busy bit has one owner.
    assign hazard    = busy[uop.rs1] | busy[uop.rs2] | busy[uop.rd];
    assign uop_ready = started & ~hazard & (~req_valid | req_ready);
    assign accept    = uop_valid & uop_ready;
    assign sb_set    = accept & uop.reg_wen & (uop.rd != '0);

    // Holds off the upstream port for the first cycle after reset.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (release_en) busy[release_rd] <= 1'b0; // Writeback retired the op.
            if (kill_en)    busy[kill_rd]    <= 1'b0; // Op dropped by flush.
            if (sb_set)     busy[uop.rd]     <= 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else if (accept) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req.pc          <= uop.pc;
            req.opnd1       <= (uop.src1_sel == SRC1_PC) ? uop.pc : rs1_data;
            req.opnd2       <= (uop.src2_sel == SRC2_RS2) ? rs2_data : uop.imm;
            req.rs2_value   <= rs2_data;
            req.imm         <= uop.imm;
            req.rd          <= uop.rd;
            req.alu_op      <= uop.alu_op;
            req.inv_flag    <= uop.inv_flag;
            req.branch_flag <= uop.branch_flag;
            req.jump_flag   <= uop.jump_flag;
            req.reg_wen     <= uop.reg_wen;
            req.mem_wen     <= uop.mem_wen;
            req.mem_ren     <= uop.mem_ren;
            req.funct3      <= uop.funct3;
        end
    end

    // A release or a kill only ever frees a bit that its op set.
    busy_release_owned: assert property (@(posedge clock) disable iff (reset)
        (!release_en || busy[release_rd]) && (!kill_en || busy[kill_rd]));

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

`include "exec_defs.svh"

module reg_file (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`EXEC_RIDX_W-1:0] rs1_addr,
    input  logic [`EXEC_RIDX_W-1:0] rs2_addr,
    output logic [`EXEC_XLEN-1:0]   rs1_data,
    output logic [`EXEC_XLEN-1:0]   rs2_data,
    input  logic                    wen,
    input  logic [`EXEC_RIDX_W-1:0] waddr,
    input  logic [`EXEC_XLEN-1:0]   wdata
);

    logic [`EXEC_XLEN-1:0] regs [`EXEC_NREGS];

    // Writes to x0 are dropped so entry 0 keeps its reset value.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `EXEC_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rs1_data = regs[rs1_addr]; // Old value on a same-cycle write.
    assign rs2_data = regs[rs2_addr];

    x0_reads_zero: assert property (@(posedge clock) disable iff (reset)
        ((rs1_addr == '0) |-> (rs1_data == '0)) and
        ((rs2_addr == '0) |-> (rs2_data == '0)));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and check the log.
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_exec_core -o tb_exec_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_exec_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// File: tb_exec_core.sv
`default_nettype none

`include "exec_defs.svh"

module tb_exec_core
    import exec_pkg::*;
();

    localparam int ALU_OPS     = 40;
    localparam int BR_OPS      = 16;
    localparam int DEP_OPS     = 12;
    localparam int FL_OPS      = 4;
    localparam int BP_OPS      = 40;
    localparam int CYCLE_LIMIT = 40 * (ALU_OPS + BR_OPS + DEP_OPS + FL_OPS + BP_OPS) + 200;

    logic    clock;
    logic    reset;
    uop_t    uop;
    logic    uop_valid;
    logic    uop_ready;
    logic    flush;
    commit_t commit;
    logic    commit_valid;
    logic    commit_ready = 1'b1;

    logic [`EXEC_XLEN-1:0] model_regs [`EXEC_NREGS];
    commit_t               exp_q [$];
    commit_t               exp_head;
    logic                  exp_have;
    logic                  bp_on = 1'b0;
    logic                  ready_draw = 1'b1;
    integer                seed = 32'hc5d1_3061;
    int                    cycles = 0;
    int                    errors = 0;
    int                    mark = 0;
    int                    issued = 0;
    int                    commits = 0;
    int                    tests = 0;
    string                 test_name;

    exec_core_top uut (
        .clock, .reset, .uop, .uop_valid, .uop_ready, .flush,
        .commit, .commit_valid, .commit_ready
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        ready_draw <= bp_on ? (($random(seed) % 3) != 0) : 1'b1; // Ready about two thirds.
    end

    always @(negedge clock) begin
        commit_ready = ready_draw;
    end

    // Retire the queue head on each consumed commit.
    always @(posedge clock) begin
        if (!reset && commit_valid && commit_ready) begin
            commits++;
            if (exp_q.size() > 0) void'(exp_q.pop_front());
        end
        exp_have <= exp_q.size() > 0;
        exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles: %0d of %0d ops committed",
                     cycles, commits, issued);
            $display("Simulation failed");
            $finish;
        end
    end

    commit_known: assert property (@(posedge clock) disable iff (reset)
        (commit_valid && commit_ready) |-> exp_have)
        else begin
            $display("%s: a commit appeared with no op outstanding", test_name);
            errors++;
        end

    commit_match: assert property (@(posedge clock) disable iff (reset)
        (commit_valid && commit_ready && exp_have) |-> (commit == exp_head))
        else begin
            $display("mismatch %s: expected %h actual %h", test_name,
                     $sampled(exp_head), $sampled(commit));
            errors++;
        end

    commit_stable: assert property (@(posedge clock) disable iff (reset)
        (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit)))
        else begin
            $display("%s: commit record changed while it was held", test_name);
            errors++;
        end

    function automatic logic [31:0] model_alu(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] s;
        s = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SLL:  return a << s;
            ALU_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ALU_SLTU: return {31'd0, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> s;
            ALU_SRA:  return (a >> s) | (~(32'hffff_ffff >> s) & {32{a[31]}}); // Sign fill.
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic uop_t random_uop(input alu_op_e op);
        uop_t u;
        u.pc          = $random(seed) & 32'hffff_fffc;
        u.rs1         = 5'($random(seed));
        u.rs2         = 5'($random(seed));
        u.rd          = 5'($random(seed));
        u.imm         = $random(seed);
        u.alu_op      = op;
        u.src1_sel    = src1_sel_e'(1'($random(seed)));
        u.src2_sel    = src2_sel_e'(1'($random(seed)));
        u.inv_flag    = 1'b0;
        u.branch_flag = 1'b0;
        u.jump_flag   = 1'b0;
        u.reg_wen     = 1'b1;
        u.mem_wen     = 1'($random(seed));
        u.mem_ren     = 1'($random(seed));
        u.funct3      = 3'($random(seed));
        return u;
    endfunction

    // In-order model: register state is updated as each op issues.
    task automatic model_issue(input uop_t u);
        commit_t     c;
        logic [31:0] a;
        logic [31:0] b;
        a = (u.src1_sel == SRC1_PC) ? u.pc : model_regs[u.rs1];
        b = (u.src2_sel == SRC2_RS2) ? model_regs[u.rs2] : u.imm;
        c.pc        = u.pc;
        c.result    = model_alu(u.alu_op, a, b);
        c.result[0] = c.result[0] ^ u.inv_flag;
        c.rd        = u.rd;
        c.reg_wen   = u.reg_wen;
        c.mem_wen   = u.mem_wen;
        c.mem_ren   = u.mem_ren;
        c.taken     = u.jump_flag | (u.branch_flag & c.result[0]);
        c.rs2_value = model_regs[u.rs2];
        if (u.reg_wen && (u.rd != '0)) model_regs[u.rd] = c.result;
        exp_q.push_back(c);
        issued++;
    endtask

    // Called on a falling edge; returns on the falling edge after the transfer.
    task automatic send_op(input uop_t u, input logic killed);
        uop       = u;
        uop_valid = 1'b1;
        #1;
        while (!uop_ready) begin
            @(negedge clock);
            #1;
        end
        if (!killed) model_issue(u);
        @(negedge clock);
        uop_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || commit_valid) @(negedge clock);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        mark      = errors;
    endtask

    task automatic finish_test();
        wait_drain();
        tests++;
        $display("test %s done: %0d errors", test_name, errors - mark);
    endtask

    initial begin
        uop_t       u;
        logic [4:0] prev_rd;
        clock     = 1'b0;
        reset     = 1'b1;
        uop       = '0;
        uop_valid = 1'b0;
        flush     = 1'b0;
        for (int i = 0; i < `EXEC_NREGS; i++) model_regs[i] = '0;

        start_test("reset");
        uop.rs1 = 5'd5;
        uop.rs2 = 5'd17;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        #1;
        assert (!uop_ready && !commit_valid && !uut.req_valid && !uut.ex_valid)
        else begin
            $display("reset: a valid or ready output is high after reset");
            errors++;
        end
        assert (uut.rs1_data == '0 && uut.rs2_data == '0)
        else begin
            $display("reset: register reads are not zero after reset");
            errors++;
        end
        @(negedge clock);
        finish_test();

        start_test("alu_ops");
        for (int i = 0; i < ALU_OPS; i++) send_op(random_uop(alu_op_e'(4'(i % 10))), 1'b0);
        finish_test();

        start_test("branch_jump");
        for (int i = 0; i < BR_OPS; i++) begin
            u = random_uop((i % 2) ? ALU_SLTU : ALU_SLT);
            u.src1_sel    = SRC1_RS1;
            u.src2_sel    = SRC2_RS2;
            u.inv_flag    = 1'($random(seed)); // Turns lt into ge.
            u.branch_flag = 1'b1;
            u.reg_wen     = 1'b0;
            if (i % 4 == 3) begin
                u = random_uop(ALU_ADD); // Link value pc plus 4.
                u.src1_sel  = SRC1_PC;
                u.src2_sel  = SRC2_IMM;
                u.imm       = 32'd4;
                u.jump_flag = 1'b1;
            end
            send_op(u, 1'b0);
        end
        finish_test();

        start_test("dependence");
        prev_rd = 5'd1;
        for (int i = 0; i < DEP_OPS; i++) begin
            u = random_uop((i % 3 == 0) ? ALU_XOR : ALU_ADD);
            u.src1_sel = SRC1_RS1;
            u.rs1      = prev_rd;
            u.rd       = (i == 5) ? 5'd0 : 5'(i + 2); // One write to x0.
            prev_rd    = u.rd;
            send_op(u, 1'b0);
        end
        finish_test();

        start_test("flush");
        u = random_uop(ALU_ADD);
        u.src1_sel = SRC1_RS1;
        u.src2_sel = SRC2_IMM;
        u.rs1      = 5'd0;
        u.rd       = 5'd7;
        u.imm      = 32'h5555_0007;
        send_op(u, 1'b0);
        wait_drain();
        u.imm = 32'hdead_0007;
        send_op(u, 1'b1);
        flush = 1'b1; // Hits the op as it enters execute.
        @(negedge clock);
        flush = 1'b0;
        u.rs1 = 5'd7;
        u.rd  = 5'd8;
        u.imm = 32'd0;
        send_op(u, 1'b0);
        u.rs1 = 5'd8;
        u.rd  = 5'd7;
        send_op(u, 1'b0);
        finish_test();

        start_test("back_pressure");
        bp_on = 1'b1;
        for (int i = 0; i < BP_OPS; i++) begin
            send_op(random_uop(alu_op_e'(4'($unsigned($random(seed)) % 10))), 1'b0);
        end
        wait_drain();
        bp_on = 1'b0;
        assert (commits == issued)
        else begin
            $display("mismatch %s: expected %0d commits actual %0d", test_name, issued, commits);
            errors++;
        end
        finish_test();

        $display("summary: %0d tests, %0d ops issued, %0d commits, %0d errors",
                 tests, issued, commits, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: writeback_stage.sv
`default_nettype none

`include "exec_defs.svh"

module writeback_stage
    import exec_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  commit_t                 ex_out,
    input  logic                    ex_valid,
    output logic                    ex_ready,
    output commit_t                 commit,
    output logic                    commit_valid,
    input  logic                    commit_ready,
    output logic                    wen,
    output logic [`EXEC_RIDX_W-1:0] waddr,
    output logic [`EXEC_XLEN-1:0]   wdata,
    output logic                    release_en,
    output logic [`EXEC_RIDX_W-1:0] release_rd
);

    logic consume;

    assign ex_ready = ~commit_valid | commit_ready;
    assign consume  = commit_valid & commit_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (ex_valid && ex_ready) begin
            commit_valid <= 1'b1;
        end else if (commit_ready) begin
            commit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (ex_valid && ex_ready) begin
            commit <= ex_out;
        end
    end

    // Register write and scoreboard release land on the consuming edge.
    assign release_en = consume & commit.reg_wen & (commit.rd != '0);
    assign release_rd = commit.rd;
    assign wen        = release_en;
    assign waddr      = commit.rd;
    assign wdata      = commit.result;

    commit_held: assert property (@(posedge clock) disable iff (reset)
        (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit)));

endmodule

`default_nettype wire
